// ==== compile.f ====
verilog/scratch_pkg.sv
verilog/line_ram_2rw.sv
verilog/mover_regs.sv
verilog/line_mover.sv
verilog/scratch_top.sv
sim/tb_scratch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the scratchpad testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_scratch_top \
  -f compile.f

# the model exits non-zero on a failed check, so its status is not used here
output="$(./obj_dir/Vtb_scratch_top 2>&1)" || true
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// ==== sim/tb_scratch_top.sv ====
`timescale 1ns/1ps

module tb_scratch_top;

  import scratch_pkg::*;

  localparam int BPL    = 4;
  localparam int AW     = 10;
  localparam int DEPTH  = 1 << AW;
  localparam int LINE_W = 8 * BPL;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              host_en;
  logic [BPL-1:0]    host_be;
  logic [AW-1:0]     host_addr;
  logic [LINE_W-1:0] host_wdata;
  logic [LINE_W-1:0] host_rdata;
  logic              reg_we;
  reg_addr_t         reg_addr;
  reg_word_t         reg_wdata;
  reg_word_t         reg_rdata;
  logic              irq;

  // byte image of what the RAM should hold
  logic [7:0]  model [DEPTH*BPL];
  logic [31:0] lfsr = 32'd93322;
  string       test_name = "reset";

  // host_rdata hold tracking
  logic              hold_armed = 1'b0;
  logic              read_next  = 1'b0;
  logic [LINE_W-1:0] rdata_prev;

  scratch_top DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_en    (host_en),
    .host_be    (host_be),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .irq        (irq)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [LINE_W-1:0] model_line(input logic [AW-1:0] addr);
    logic [LINE_W-1:0] line;
    for (int b = 0; b < BPL; b++) begin
      line[b*8 +: 8] = model[int'(addr)*BPL + b];
    end
    return line;
  endfunction

  task automatic check_value(input string what, input logic [LINE_W-1:0] expected,
                             input logic [LINE_W-1:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch in %s (%s): expected %h, actual %h",
               test_name, what, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // host_rdata may only change on an edge that samples a host read
  always @(negedge clk) begin
    if (hold_armed && !read_next) begin
      assert (host_rdata === rdata_prev) else begin
        $display("Mismatch in %s (host_rdata hold): expected %h, actual %h",
                 test_name, rdata_prev, host_rdata);
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
    end
    rdata_prev = host_rdata;
    read_next  = host_en && (host_be == '0);
    hold_armed = arst_n;
  end

  task automatic host_write(input logic [AW-1:0] addr, input logic [BPL-1:0] be,
                            input logic [LINE_W-1:0] data);
    @(posedge clk);
    host_en    <= 1'b1;
    host_be    <= be;
    host_addr  <= addr;
    host_wdata <= data;
    for (int b = 0; b < BPL; b++) begin
      if (be[b]) begin
        model[int'(addr)*BPL + b] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic host_idle();
    @(posedge clk);
    host_en <= 1'b0;
    host_be <= '0;
  endtask

  // random full lines over a job's source range
  task automatic write_random_lines(input logic [AW-1:0] base, input int lines);
    for (int k = 0; k < lines; k++) begin
      host_write(base + AW'(k), '1, rand_bits(LINE_W));
    end
    host_idle();
  endtask

  // address goes out on one edge, data is checked after the next
  task automatic host_read_check(input logic [AW-1:0] addr);
    @(posedge clk);
    host_en   <= 1'b1;
    host_be   <= '0;
    host_addr <= addr;
    @(posedge clk);
    host_en <= 1'b0;
    @(negedge clk);
    check_value($sformatf("host line %0d", addr), model_line(addr), host_rdata);
  endtask

  task automatic check_all_lines();
    for (int a = 0; a < DEPTH; a++) begin
      host_read_check(AW'(a));
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_word_t data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic reg_read_check(input reg_addr_t addr, input reg_word_t expected,
                                input string what);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);
    check_value(what, expected, reg_rdata);
  endtask

  task automatic program_job(input logic [AW-1:0] src, input logic [AW-1:0] dst,
                             input int lines, input reg_word_t pattern);
    reg_write(REG_SRC, reg_word_t'(src));
    reg_write(REG_DST, reg_word_t'(dst));
    reg_write(REG_COUNT, reg_word_t'(lines));
    reg_write(REG_PATTERN, pattern);
  endtask

  // cycles counts edges after the call until irq is seen high
  task automatic wait_irq(input int limit, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!irq && (cycles < limit)) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (!irq) begin
      $display("Timeout in %s: the job never finished within %0d cycles", test_name, limit);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic copy_model(input logic [AW-1:0] src, input logic [AW-1:0] dst,
                            input int lines);
    logic [AW-1:0] s;
    logic [AW-1:0] d;
    for (int k = 0; k < lines; k++) begin
      s = src + AW'(k);
      d = dst + AW'(k);
      for (int b = 0; b < BPL; b++) begin
        model[int'(d)*BPL + b] = model[int'(s)*BPL + b];
      end
    end
  endtask

  // pattern bytes go out low byte first and wrap every four bytes
  task automatic fill_model(input logic [AW-1:0] dst, input int lines, input reg_word_t pattern);
    logic [AW-1:0] d;
    reg_word_t     rot;
    for (int k = 0; k < lines; k++) begin
      d   = dst + AW'(k);
      rot = pattern;
      for (int b = 0; b < BPL; b++) begin
        model[int'(d)*BPL + b] = rot[7:0];
        rot = {rot[7:0], rot[31:8]};
      end
    end
  endtask

  initial begin
    int                l_lines;
    int                cycles;
    logic [AW-1:0]     src;
    logic [AW-1:0]     dst;
    logic [AW-1:0]     addr;
    logic [BPL-1:0]    be;
    logic [LINE_W-1:0] data;
    reg_word_t         pattern;

    arst_n     = 1'b0;
    host_en    = 1'b0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    for (int i = 0; i < DEPTH*BPL; i++) begin
      model[i] = 8'h00;
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    check_value("irq", '0, LINE_W'(irq));
    for (int r = 0; r <= 5; r++) begin
      reg_read_check(reg_addr_t'(r), '0, $sformatf("register %0d", r));
    end

    // two partial writes to one line, then read back
    test_name = "host byte writes";
    for (int n = 0; n < 24; n++) begin
      addr = AW'(rand_bits(AW));
      for (int w = 0; w < 2; w++) begin
        be   = BPL'(rand_bits(BPL));
        data = rand_bits(LINE_W);
        host_write(addr, be, data);
      end
      host_idle();
      host_read_check(addr);
    end
    addr = AW'(rand_bits(AW));
    host_read_check(addr);
    host_write(addr + AW'(1), '1, rand_bits(LINE_W));
    host_write(addr + AW'(2), '1, rand_bits(LINE_W));
    host_idle();
    @(negedge clk);
    check_value("host_rdata over writes", model_line(addr), host_rdata);

    test_name = "copy";
    src     = AW'(rand_bits(AW));
    dst     = src + AW'(32 + rand_bits(7));
    l_lines = 1 + int'(rand_bits(4));
    write_random_lines(src, l_lines);
    program_job(src, dst, l_lines, '0);
    reg_write(REG_CTRL, reg_word_t'(1 << CTRL_START_BIT));
    wait_irq(4 * l_lines + 8, cycles);
    check_value("copy cycles to irq", LINE_W'(2 * l_lines + 1), LINE_W'(cycles));
    copy_model(src, dst, l_lines);
    check_all_lines();
    reg_write(REG_STATUS, '0);

    test_name = "fill";
    dst     = AW'(rand_bits(AW));
    l_lines = 1 + int'(rand_bits(4));
    pattern = rand_bits(32);
    program_job('0, dst, l_lines, pattern);
    reg_write(REG_CTRL, reg_word_t'((1 << CTRL_START_BIT) | (1 << CTRL_FILL_BIT)));
    wait_irq(2 * l_lines + 8, cycles);
    check_value("fill cycles to irq", LINE_W'(l_lines + 1), LINE_W'(cycles));
    fill_model(dst, l_lines, pattern);
    check_all_lines();
    reg_write(REG_STATUS, '0);

    test_name = "busy rules";
    src = AW'(rand_bits(AW));
    dst = src + AW'(32 + rand_bits(7));
    write_random_lines(src, 16);
    program_job(src, dst, 16, '0);
    reg_write(REG_CTRL, reg_word_t'(1 << CTRL_START_BIT));
    reg_read_check(REG_STATUS, reg_word_t'(1 << STATUS_BUSY_BIT), "status while busy");
    reg_write(REG_CTRL, reg_word_t'(1 << CTRL_START_BIT));
    reg_write(REG_SRC, reg_word_t'(~src));
    reg_read_check(REG_SRC, reg_word_t'(src), "source held while busy");
    wait_irq(80, cycles);
    reg_read_check(REG_STATUS, reg_word_t'(1 << STATUS_DONE_BIT), "status after job");
    reg_write(REG_STATUS, '0);
    @(negedge clk);
    check_value("irq after status write", '0, LINE_W'(irq));
    reg_read_check(REG_STATUS, '0, "status after clear");
    copy_model(src, dst, 16);
    check_all_lines();

    // host lines well away from both job ranges
    test_name = "host during copy";
    src = AW'(rand_bits(AW));
    dst = src + AW'(32 + rand_bits(7));
    write_random_lines(src, 16);
    program_job(src, dst, 16, '0);
    reg_write(REG_CTRL, reg_word_t'(1 << CTRL_START_BIT));
    for (int k = 0; k < 4; k++) begin
      data = rand_bits(LINE_W);
      host_write(src + AW'(256 + k), '1, data);
    end
    host_idle();
    wait_irq(80, cycles);
    copy_model(src, dst, 16);
    check_all_lines();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verilog/line_mover.sv ====
`timescale 1ns/1ps

module line_mover #(
  parameter int BYTES_PER_LINE = 4,
  parameter int ADDR_WIDTH     = 10
) (
  input  logic                        clk,
  input  logic                        arst_n,

  input  logic                        start,
  input  logic                        fill_mode,
  input  logic [ADDR_WIDTH-1:0]       src_line,
  input  logic [ADDR_WIDTH-1:0]       dst_line,
  input  logic [ADDR_WIDTH:0]         line_count,
  input  scratch_pkg::reg_word_t      pattern,

  output logic                        busy,
  output logic                        finish,

  output logic                        ram_en,
  output logic [BYTES_PER_LINE-1:0]   ram_be,
  output logic [ADDR_WIDTH-1:0]       ram_addr,
  output logic [8*BYTES_PER_LINE-1:0] ram_wdata,
  input  logic [8*BYTES_PER_LINE-1:0] ram_rdata
);

  import scratch_pkg::*;

  localparam int LINE_W = 8 * BYTES_PER_LINE;
  localparam int CNT_W  = ADDR_WIDTH + 1;

  mover_state_t      state;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [CNT_W-1:0]  remaining;
  logic              fill_q;
  reg_word_t         pattern_q;
  logic [LINE_W-1:0] fill_line;
  logic              last_line;
  logic              writing;

  assign last_line = (remaining == CNT_W'(1));
  assign writing   = (state == MV_WRITE) || (state == MV_FILL);

  // one line in flight: copy reads a line, then writes it, then moves on
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= MV_IDLE;
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      remaining <= '0;
      fill_q    <= 1'b0;
    end else begin
      case (state)
        MV_IDLE: begin
          if (start) begin
            rd_ptr    <= src_line;
            wr_ptr    <= dst_line;
            remaining <= line_count;
            fill_q    <= fill_mode;
            state     <= fill_mode ? MV_FILL : MV_READ;
          end
        end
        MV_READ: begin
          rd_ptr <= rd_ptr + 1'b1;
          state  <= MV_WRITE;
        end
        MV_WRITE: begin
          wr_ptr    <= wr_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          state     <= last_line ? MV_IDLE : MV_READ;
        end
        MV_FILL: begin
          wr_ptr    <= wr_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          if (last_line) begin
            state <= MV_IDLE;
          end
        end
        default: state <= MV_IDLE;
      endcase
    end
  end

  // fill word captured with the job
  always_ff @(posedge clk) begin
    if ((state == MV_IDLE) && start) begin
      pattern_q <= pattern;
    end
  end

  // pattern repeated byte by byte across the line
  always_comb begin
    for (int b = 0; b < BYTES_PER_LINE; b++) begin
      fill_line[b*8 +: 8] = pattern_q[(b % 4)*8 +: 8];
    end
  end

  assign busy   = (state != MV_IDLE);
  assign finish = writing && last_line;

  // port B drive
  assign ram_en    = busy;
  assign ram_be    = writing ? {BYTES_PER_LINE{1'b1}} : '0;
  assign ram_addr  = (state == MV_READ) ? rd_ptr : wr_ptr;
  // read data from the previous cycle is still held on a write cycle
  assign ram_wdata = fill_q ? fill_line : ram_rdata;

endmodule

// ==== verilog/line_ram_2rw.sv ====
`timescale 1ns/1ps

module line_ram_2rw #(
  parameter int BYTES_PER_LINE = 4,
  parameter int ADDR_WIDTH     = 10
) (
  input  logic                        clk,

  input  logic                        a_en,
  input  logic [BYTES_PER_LINE-1:0]   a_be,
  input  logic [ADDR_WIDTH-1:0]       a_addr,
  input  logic [8*BYTES_PER_LINE-1:0] a_wdata,
  output logic [8*BYTES_PER_LINE-1:0] a_rdata,

  input  logic                        b_en,
  input  logic [BYTES_PER_LINE-1:0]   b_be,
  input  logic [ADDR_WIDTH-1:0]       b_addr,
  input  logic [8*BYTES_PER_LINE-1:0] b_wdata,
  output logic [8*BYTES_PER_LINE-1:0] b_rdata
);

  localparam int LINE_W = 8 * BYTES_PER_LINE;
  localparam int DEPTH  = 1 << ADDR_WIDTH;

  (* ram_style = "ultra" *)
  logic [LINE_W-1:0] mem [DEPTH];

  // byte writes from both ports
  // same-line writes in one cycle are left undefined
  always @(posedge clk) begin
    if (a_en) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (a_be[i]) begin
          mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
        end
      end
    end
    if (b_en) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (b_be[i]) begin
          mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8];
        end
      end
    end
  end

  // read registers load only on enabled cycles without a byte write
  always_ff @(posedge clk) begin
    if (a_en && !(|a_be)) begin
      a_rdata <= mem[a_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (b_en && !(|b_be)) begin
      b_rdata <= mem[b_addr];
    end
  end

  // contents start at zero in simulation
  initial begin
    for (int k = 0; k < DEPTH; k++) begin
      mem[k] = '0;
    end
  end

endmodule

// ==== verilog/mover_regs.sv ====
`timescale 1ns/1ps

module mover_regs #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  arst_n,

  input  logic                  reg_we,
  input  scratch_pkg::reg_addr_t reg_addr,
  input  scratch_pkg::reg_word_t reg_wdata,
  output scratch_pkg::reg_word_t reg_rdata,

  input  logic                  busy,
  input  logic                  finish,

  output logic                  start,
  output logic                  fill_mode,
  output logic [ADDR_WIDTH-1:0] src_line,
  output logic [ADDR_WIDTH-1:0] dst_line,
  output logic [ADDR_WIDTH:0]   line_count,
  output scratch_pkg::reg_word_t pattern,
  output logic                  irq
);

  import scratch_pkg::*;

  logic done;
  logic job_lock;
  logic ctrl_wr;
  logic start_req;

  // the engine samples the job one edge after start, so the start
  // cycle is locked as well as the busy period
  assign job_lock = busy | start;

  assign ctrl_wr   = reg_we && (reg_addr == REG_CTRL);
  assign start_req = ctrl_wr && reg_wdata[CTRL_START_BIT] && !job_lock &&
                     (line_count != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start      <= 1'b0;
      fill_mode  <= 1'b0;
      src_line   <= '0;
      dst_line   <= '0;
      line_count <= '0;
      pattern    <= '0;
    end else begin
      start <= start_req;
      if (ctrl_wr) begin
        fill_mode <= reg_wdata[CTRL_FILL_BIT];
      end
      if (reg_we && !job_lock) begin
        case (reg_addr)
          REG_SRC:     src_line   <= reg_wdata[ADDR_WIDTH-1:0];
          REG_DST:     dst_line   <= reg_wdata[ADDR_WIDTH-1:0];
          REG_COUNT:   line_count <= reg_wdata[ADDR_WIDTH:0];
          REG_PATTERN: pattern    <= reg_wdata;
          default:     ;
        endcase
      end
    end
  end

  // sticky done, cleared by a status write or by the next start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else if (finish) begin
      done <= 1'b1;
    end else if ((reg_we && (reg_addr == REG_STATUS)) || start) begin
      done <= 1'b0;
    end
  end

  assign irq = done;

  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      REG_CTRL:    reg_rdata[CTRL_FILL_BIT] = fill_mode;
      REG_SRC:     reg_rdata = reg_word_t'(src_line);
      REG_DST:     reg_rdata = reg_word_t'(dst_line);
      REG_COUNT:   reg_rdata = reg_word_t'(line_count);
      REG_PATTERN: reg_rdata = pattern;
      REG_STATUS: begin
        reg_rdata[STATUS_BUSY_BIT] = busy;
        reg_rdata[STATUS_DONE_BIT] = done;
      end
      default:     reg_rdata = '0;
    endcase
  end

endmodule

// ==== verilog/scratch_pkg.sv ====
package scratch_pkg;

  // one register data word
  typedef logic [31:0] reg_word_t;

  // register index on the register port
  typedef logic [2:0] reg_addr_t;

  // register map
  localparam reg_addr_t REG_CTRL    = 3'd0;
  localparam reg_addr_t REG_SRC     = 3'd1;
  localparam reg_addr_t REG_DST     = 3'd2;
  localparam reg_addr_t REG_COUNT   = 3'd3;
  localparam reg_addr_t REG_PATTERN = 3'd4;
  localparam reg_addr_t REG_STATUS  = 3'd5;

  // control register bits
  // writing 1 to start launches a job, fill selects fill (1) or copy (0)
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_FILL_BIT  = 1;

  // status register bits
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // line engine states
  typedef enum logic [1:0] {
    MV_IDLE,
    MV_READ,
    MV_WRITE,
    MV_FILL
  } mover_state_t;

endpackage

// ==== verilog/scratch_top.sv ====
`timescale 1ns/1ps

module scratch_top #(
  parameter int BYTES_PER_LINE = 4,
  parameter int ADDR_WIDTH     = 10
) (
  input  logic                        clk,
  input  logic                        arst_n,

  // host line port
  input  logic                        host_en,
  input  logic [BYTES_PER_LINE-1:0]   host_be,
  input  logic [ADDR_WIDTH-1:0]       host_addr,
  input  logic [8*BYTES_PER_LINE-1:0] host_wdata,
  output logic [8*BYTES_PER_LINE-1:0] host_rdata,

  // engine register port
  input  logic                        reg_we,
  input  scratch_pkg::reg_addr_t      reg_addr,
  input  scratch_pkg::reg_word_t      reg_wdata,
  output scratch_pkg::reg_word_t      reg_rdata,

  output logic                        irq
);

  import scratch_pkg::*;

  localparam int LINE_W = 8 * BYTES_PER_LINE;

  // register block to engine
  logic                  start;
  logic                  fill_mode;
  logic [ADDR_WIDTH-1:0] src_line;
  logic [ADDR_WIDTH-1:0] dst_line;
  logic [ADDR_WIDTH:0]   line_count;
  reg_word_t             pattern;
  logic                  busy;
  logic                  finish;

  // engine to port B
  logic                      b_en;
  logic [BYTES_PER_LINE-1:0] b_be;
  logic [ADDR_WIDTH-1:0]     b_addr;
  logic [LINE_W-1:0]         b_wdata;
  logic [LINE_W-1:0]         b_rdata;

  // host owns port A outright
  line_ram_2rw #(
    .BYTES_PER_LINE (BYTES_PER_LINE),
    .ADDR_WIDTH     (ADDR_WIDTH)
  ) u_ram (
    .clk     (clk),
    .a_en    (host_en),
    .a_be    (host_be),
    .a_addr  (host_addr),
    .a_wdata (host_wdata),
    .a_rdata (host_rdata),
    .b_en    (b_en),
    .b_be    (b_be),
    .b_addr  (b_addr),
    .b_wdata (b_wdata),
    .b_rdata (b_rdata)
  );

  mover_regs #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .busy       (busy),
    .finish     (finish),
    .start      (start),
    .fill_mode  (fill_mode),
    .src_line   (src_line),
    .dst_line   (dst_line),
    .line_count (line_count),
    .pattern    (pattern),
    .irq        (irq)
  );

  line_mover #(
    .BYTES_PER_LINE (BYTES_PER_LINE),
    .ADDR_WIDTH     (ADDR_WIDTH)
  ) u_mover (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .fill_mode  (fill_mode),
    .src_line   (src_line),
    .dst_line   (dst_line),
    .line_count (line_count),
    .pattern    (pattern),
    .busy       (busy),
    .finish     (finish),
    .ram_en     (b_en),
    .ram_be     (b_be),
    .ram_addr   (b_addr),
    .ram_wdata  (b_wdata),
    .ram_rdata  (b_rdata)
  );

endmodule
